//--- kitchen_pkg.sv
package kitchen_pkg;

    // game dimensions
    localparam int num_spaces = 2;
    localparam int max_orders = 4;
    localparam int item_bits  = 4;
    localparam int time_bits  = 5;
    localparam int score_bits = 12;

    // item codes on the counter
    localparam logic [item_bits-1:0] item_empty = 4'd0;
    localparam logic [item_bits-1:0] item_dish  = 4'd4;

    // index of the serving window, space 0 only holds items
    localparam int serve_space = 1;

    // scoring
    localparam int base_points = 20;
    localparam int bonus_high  = 6;
    localparam int bonus_mid   = 4;
    localparam int bonus_low   = 2;

    // seconds left that must be exceeded to earn each bonus
    localparam int bonus_high_above = 15;
    localparam int bonus_mid_above  = 10;
    localparam int bonus_low_above  = 5;

    // config register addresses
    localparam logic [1:0] addr_ticks_per_second = 2'd0;
    localparam logic [1:0] addr_round_seconds    = 2'd1;
    localparam logic [1:0] addr_order_interval   = 2'd2;
    localparam logic [1:0] addr_order_timing     = 2'd3;

    // config values after reset
    localparam logic [15:0] reset_ticks_per_second = 16'd5;
    localparam logic [7:0]  reset_round_seconds    = 8'd60;
    localparam logic [4:0]  reset_order_interval   = 5'd6;
    localparam logic [4:0]  reset_order_lifetime   = 5'd30;
    localparam logic [5:0]  reset_penalty          = 6'd10;

    typedef struct packed {
        logic [15:0] ticks_per_second;
        logic [7:0]  round_seconds;
        logic [4:0]  order_interval;
        logic [4:0]  order_lifetime;
        logic [5:0]  expire_penalty;
    } kitchen_cfg_t;

    // one item code per counter space
    typedef logic [num_spaces-1:0][item_bits-1:0] space_array_t;

    // queue is oldest first, active is a thermometer mask from bit 0
    typedef struct packed {
        logic [max_orders-1:0]                active;
        logic [max_orders-1:0][time_bits-1:0] times;
    } order_state_t;

endpackage

//--- kitchen_config_regs.sv
`timescale 1ns/1ps

module kitchen_config_regs (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      cfg_write,
    input  logic [1:0]                cfg_addr,
    input  logic [15:0]               cfg_data,
    output kitchen_pkg::kitchen_cfg_t cfg
);

    // write-only settings, new values are seen on the next edge
    always_ff @(posedge clock) begin
        if (reset) begin
            cfg.ticks_per_second <= kitchen_pkg::reset_ticks_per_second;
            cfg.round_seconds    <= kitchen_pkg::reset_round_seconds;
            cfg.order_interval   <= kitchen_pkg::reset_order_interval;
            cfg.order_lifetime   <= kitchen_pkg::reset_order_lifetime;
            cfg.expire_penalty   <= kitchen_pkg::reset_penalty;
        end else if (cfg_write) begin
            case (cfg_addr)
                kitchen_pkg::addr_ticks_per_second: begin
                    cfg.ticks_per_second <= cfg_data;
                end
                kitchen_pkg::addr_round_seconds: begin
                    cfg.round_seconds <= cfg_data[7:0];
                end
                kitchen_pkg::addr_order_interval: begin
                    cfg.order_interval <= cfg_data[4:0];
                end
                default: begin
                    // lifetime and penalty share one word
                    cfg.order_lifetime <= cfg_data[4:0];
                    cfg.expire_penalty <= cfg_data[13:8];
                end
            endcase
        end
    end

endmodule

//--- game_timer.sv
`timescale 1ns/1ps

module game_timer (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      start,
    input  kitchen_pkg::kitchen_cfg_t cfg,
    output logic                      second_tick,
    output logic                      timer_go,
    output logic [7:0]                round_left
);

    // cycles counted within the current second
    logic [15:0] prescale;
    logic [16:0] prescale_next;

    // round runs while seconds remain
    assign timer_go = (round_left != 8'd0);

    assign prescale_next = {1'b0, prescale} + 17'd1;

    // a setting of 0 or 1 ticks every cycle
    assign second_tick = timer_go && (prescale_next >= {1'b0, cfg.ticks_per_second});

    always_ff @(posedge clock) begin
        if (reset) begin
            prescale   <= '0;
            round_left <= '0;
        end else if (start) begin
            // restart the round and realign the second boundary
            prescale   <= '0;
            round_left <= cfg.round_seconds;
        end else if (second_tick) begin
            prescale   <= '0;
            round_left <= round_left - 8'd1;
        end else if (timer_go) begin
            prescale <= prescale_next[15:0];
        end
    end

endmodule

//--- serving_station.sv
`timescale 1ns/1ps

module serving_station (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      place_strobe,
    input  logic                      place_space,
    input  logic [3:0]                place_item,
    input  logic                      serve_clear,
    output kitchen_pkg::space_array_t spaces
);

    always_ff @(posedge clock) begin
        if (reset) begin
            spaces <= {kitchen_pkg::num_spaces{kitchen_pkg::item_empty}};
        end else begin
            for (int i = 0; i < kitchen_pkg::num_spaces; i++) begin
                if (serve_clear && (i == kitchen_pkg::serve_space)) begin
                    // a served dish leaves the window, even over a new placement
                    spaces[i] <= kitchen_pkg::item_empty;
                end else if (place_strobe && (int'(place_space) == i)) begin
                    spaces[i] <= place_item;
                end
            end
        end
    end

endmodule

//--- order_tracker.sv
`timescale 1ns/1ps

module order_tracker (
    input  logic                      clock,
    input  logic                      reset,
    input  kitchen_pkg::kitchen_cfg_t cfg,
    input  logic                      timer_go,
    input  logic                      second_tick,
    input  kitchen_pkg::space_array_t spaces,
    output logic                      serve_clear,
    output kitchen_pkg::order_state_t order_state,
    output logic signed [11:0]        score
);

    logic [kitchen_pkg::max_orders-1:0]                          active;
    logic [kitchen_pkg::max_orders-1:0][kitchen_pkg::time_bits-1:0] times;
    logic [kitchen_pkg::max_orders-1:0][kitchen_pkg::time_bits-1:0] shifted_times;
    logic [kitchen_pkg::time_bits-1:0]                           interval_count;
    logic [kitchen_pkg::time_bits-1:0]                           oldest_time;

    // queue with one more order, and the slot that it fills
    logic [kitchen_pkg::max_orders-1:0] grown_active;
    logic [kitchen_pkg::max_orders-1:0] new_slot;

    logic dish_ready;
    logic do_expire;
    logic do_add;

    logic signed [kitchen_pkg::score_bits-1:0] serve_points;
    logic signed [kitchen_pkg::score_bits-1:0] penalty_points;

    assign oldest_time = times[0];

    assign dish_ready = (spaces[kitchen_pkg::serve_space] == kitchen_pkg::item_dish);

    // serving has top priority, the pulse clears the window on the next edge
    assign serve_clear = timer_go && dish_ready && active[0];

    // only the oldest order can run out
    assign do_expire = active[0] && (oldest_time == '0);

    assign grown_active = {active[kitchen_pkg::max_orders-2:0], 1'b1};
    assign new_slot     = grown_active & ~active;

    // an empty queue refills at once, otherwise wait for the interval
    assign do_add = (active == '0)
                 || ((interval_count >= cfg.order_interval)
                     && !active[kitchen_pkg::max_orders-1]);

    // retiring the oldest order brings a fresh countdown in at the top
    assign shifted_times = {cfg.order_lifetime, times[kitchen_pkg::max_orders-1:1]};

    // points for a served order depend on how much time is left
    always_comb begin
        if (oldest_time > kitchen_pkg::bonus_high_above) begin
            serve_points = kitchen_pkg::score_bits'(kitchen_pkg::base_points
                                                    + kitchen_pkg::bonus_high);
        end else if (oldest_time > kitchen_pkg::bonus_mid_above) begin
            serve_points = kitchen_pkg::score_bits'(kitchen_pkg::base_points
                                                    + kitchen_pkg::bonus_mid);
        end else if (oldest_time > kitchen_pkg::bonus_low_above) begin
            serve_points = kitchen_pkg::score_bits'(kitchen_pkg::base_points
                                                    + kitchen_pkg::bonus_low);
        end else begin
            serve_points = kitchen_pkg::score_bits'(kitchen_pkg::base_points);
        end
    end

    // penalty is unsigned, widen with zeros
    assign penalty_points = kitchen_pkg::score_bits'(cfg.expire_penalty);

    always_ff @(posedge clock) begin
        if (reset) begin
            active         <= '0;
            times          <= '0;
            interval_count <= '0;
            score          <= '0;
        end else if (timer_go) begin
            if (serve_clear) begin
                active <= active >> 1;
                times  <= shifted_times;
                score  <= score + serve_points;
            end else if (do_expire) begin
                active <= active >> 1;
                times  <= shifted_times;
                score  <= score - penalty_points;
            end else if (do_add) begin
                active         <= grown_active;
                interval_count <= '0;
                for (int i = 0; i < kitchen_pkg::max_orders; i++) begin
                    if (new_slot[i]) begin
                        times[i] <= cfg.order_lifetime;
                    end
                end
            end else if (second_tick) begin
                for (int i = 0; i < kitchen_pkg::max_orders; i++) begin
                    // stop at 0 so a waiting order cannot wrap around
                    if (active[i] && (times[i] != '0)) begin
                        times[i] <= times[i] - 1'b1;
                    end
                end
                // holds at the top while the queue is full
                if (interval_count != '1) begin
                    interval_count <= interval_count + 1'b1;
                end
            end
        end
    end

    assign order_state = '{active: active, times: times};

endmodule

//--- kitchen_top.sv
`timescale 1ns/1ps

module kitchen_top (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      cfg_write,
    input  logic [1:0]                cfg_addr,
    input  logic [15:0]               cfg_data,
    input  logic                      start,
    input  logic                      place_strobe,
    input  logic                      place_space,
    input  logic [3:0]                place_item,
    output kitchen_pkg::space_array_t spaces,
    output kitchen_pkg::order_state_t order_state,
    output logic signed [11:0]        score,
    output logic                      timer_go,
    output logic [7:0]                round_left
);

    kitchen_pkg::kitchen_cfg_t cfg;
    logic                      second_tick;
    logic                      serve_clear;

    kitchen_config_regs config_regs (
        .clock     (clock),
        .reset     (reset),
        .cfg_write (cfg_write),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .cfg       (cfg)
    );

    game_timer timer (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .cfg         (cfg),
        .second_tick (second_tick),
        .timer_go    (timer_go),
        .round_left  (round_left)
    );

    serving_station station (
        .clock        (clock),
        .reset        (reset),
        .place_strobe (place_strobe),
        .place_space  (place_space),
        .place_item   (place_item),
        .serve_clear  (serve_clear),
        .spaces       (spaces)
    );

    // scoring side sees the counter and the round clock
    order_tracker tracker (
        .clock       (clock),
        .reset       (reset),
        .cfg         (cfg),
        .timer_go    (timer_go),
        .second_tick (second_tick),
        .spaces      (spaces),
        .serve_clear (serve_clear),
        .order_state (order_state),
        .score       (score)
    );

endmodule

//--- kitchen_top_tb.sv
`timescale 1ns/1ps

module kitchen_top_tb;

    logic        clock;
    logic        reset;
    logic        cfg_write;
    logic [1:0]  cfg_addr;
    logic [15:0] cfg_data;
    logic        start;
    logic        place_strobe;
    logic        place_space;
    logic [3:0]  place_item;

    kitchen_pkg::space_array_t spaces;
    kitchen_pkg::order_state_t order_state;
    logic signed [11:0]        score;
    logic                      timer_go;
    logic [7:0]                round_left;

    // settings the testbench has written, used for expected values
    int lifetime_cfg;
    int penalty_cfg;
    int interval_cfg;

    int    errors;
    int    tests_run;
    int    tests_failed;
    int    errors_at_start;
    string test_name;

    kitchen_top uut (
        .clock        (clock),
        .reset        (reset),
        .cfg_write    (cfg_write),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .start        (start),
        .place_strobe (place_strobe),
        .place_space  (place_space),
        .place_item   (place_item),
        .spaces       (spaces),
        .order_state  (order_state),
        .score        (score),
        .timer_go     (timer_go),
        .round_left   (round_left)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // points for a served order, from the time left on the oldest order
    function automatic int points_for(int t);
        if (t > 15) return 26;
        else if (t > 10) return 24;
        else if (t > 5) return 22;
        else return 20;
    endfunction

    logic serve_now;
    logic expire_now;
    assign serve_now  = timer_go && (spaces[1] == 4'd4) && order_state.active[0];
    assign expire_now = timer_go && !serve_now && order_state.active[0]
                        && (order_state.times[0] == 5'd0);

    // state from the previous edge
    logic                      prev_serve;
    logic                      prev_expire;
    logic                      prev_go;
    logic signed [11:0]        prev_score;
    int                        prev_time0;
    kitchen_pkg::order_state_t prev_state;

    always_ff @(posedge clock) begin
        prev_serve  <= serve_now;
        prev_expire <= expire_now;
        prev_go     <= timer_go;
        prev_score  <= score;
        prev_time0  <= int'(order_state.times[0]);
        prev_state  <= order_state;
    end

    serve_score: assert property (@(posedge clock) disable iff (reset)
        prev_serve |-> (int'(score) - int'(prev_score)) == points_for(prev_time0))
    else begin
        errors++;
        $display("[ERROR] %s: serve score expected %0d actual %0d", test_name,
                 int'(prev_score) + points_for(prev_time0), score);
    end

    serve_shift: assert property (@(posedge clock) disable iff (reset)
        prev_serve |-> (order_state.active == (prev_state.active >> 1))
                       && (int'(order_state.times[3]) == lifetime_cfg)
                       && (spaces[1] == 4'd0))
    else begin
        errors++;
        $display("[ERROR] %s: after serve expected mask %b top %0d space 0 actual %b %0d %0d",
                 test_name, prev_state.active >> 1, lifetime_cfg,
                 order_state.active, order_state.times[3], spaces[1]);
    end

    expire_charge: assert property (@(posedge clock) disable iff (reset)
        prev_expire |-> ((int'(prev_score) - int'(score)) == penalty_cfg)
                        && (order_state.active == (prev_state.active >> 1)))
    else begin
        errors++;
        $display("[ERROR] %s: expiry expected score %0d mask %b actual %0d %b", test_name,
                 int'(prev_score) - penalty_cfg, prev_state.active >> 1,
                 score, order_state.active);
    end

    score_steady: assert property (@(posedge clock) disable iff (reset)
        (!prev_serve && !prev_expire) |-> (score == prev_score))
    else begin
        errors++;
        $display("[ERROR] %s: score expected %0d actual %0d", test_name, prev_score, score);
    end

    frozen_state: assert property (@(posedge clock) disable iff (reset)
        !prev_go |-> (order_state == prev_state))
    else begin
        errors++;
        $display("[ERROR] %s: order state expected %h actual %h", test_name,
                 prev_state, order_state);
    end

    queue_mask: assert property (@(posedge clock) disable iff (reset)
        order_state.active inside {4'b0000, 4'b0001, 4'b0011, 4'b0111, 4'b1111})
    else begin
        errors++;
        $display("[ERROR] %s: mask expected thermometer actual %b", test_name,
                 order_state.active);
    end

    task automatic check_value(string what, int expected, int actual);
        assert (expected == actual)
        else begin
            errors++;
            $display("[ERROR] %s: %s expected %0d actual %0d", test_name, what,
                     expected, actual);
        end
    endtask

    task automatic abort_on_timeout(string what);
        $display("timeout in %s while waiting for %s", test_name, what);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic begin_test(string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed", test_name);
        end
    endtask

    task automatic write_cfg(logic [1:0] addr, logic [15:0] data);
        @(posedge clock);
        cfg_write <= 1'b1;
        cfg_addr  <= addr;
        cfg_data  <= data;
        @(posedge clock);
        cfg_write <= 1'b0;
    endtask

    task automatic place(logic space, logic [3:0] item);
        @(posedge clock);
        place_strobe <= 1'b1;
        place_space  <= space;
        place_item   <= item;
        @(posedge clock);
        place_strobe <= 1'b0;
        #1;
    endtask

    task automatic idle_cycles(int n);
        repeat (n) @(posedge clock);
        #1;
    endtask

    // waits for the active mask to change, counting round steps meanwhile
    task automatic wait_new_order(output int steps);
        logic [3:0] mask;
        logic [7:0] last_round;
        int         n;
        mask       = order_state.active;
        last_round = round_left;
        steps      = 0;
        n          = 0;
        while (order_state.active == mask && n < 2000) begin
            @(posedge clock);
            #1;
            n++;
            if (round_left != last_round) begin
                steps++;
                last_round = round_left;
            end
        end
        if (order_state.active == mask) abort_on_timeout("a new order");
    endtask

    initial begin
        int          n;
        int          r;
        int          steps;
        logic [3:0]  item;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "setup";
        void'($urandom(32'h670f));
        reset        = 1'b1;
        cfg_write    = 1'b0;
        cfg_addr     = 2'd0;
        cfg_data     = 16'd0;
        start        = 1'b0;
        place_strobe = 1'b0;
        place_space  = 1'b0;
        place_item   = 4'd0;
        lifetime_cfg = 30;
        penalty_cfg  = 10;
        interval_cfg = 6;
        repeat (8) @(posedge clock);
        reset <= 1'b0;

        begin_test("reset_and_config");
        @(posedge clock);
        #1;
        check_value("timer_go", 0, int'(timer_go));
        check_value("score", 0, int'(score));
        check_value("active mask", 0, int'(order_state.active));
        check_value("spaces", 0, int'(spaces));
        write_cfg(2'd0, 16'd4);
        write_cfg(2'd1, 16'd100);
        interval_cfg = 3;
        write_cfg(2'd2, 16'd3);
        lifetime_cfg = 20;
        penalty_cfg  = 7;
        write_cfg(2'd3, 16'h0714);
        end_test();

        begin_test("round_start");
        @(posedge clock);
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
        #1;
        check_value("timer_go after start", 1, int'(timer_go));
        check_value("round_left after start", 100, int'(round_left));
        @(posedge clock);
        #1;
        check_value("first order mask", 1, int'(order_state.active));
        check_value("first order time", lifetime_cfg, int'(order_state.times[0]));
        end_test();

        begin_test("tick_period");
        r = round_left;
        n = 0;
        while (round_left == r[7:0] && n < 100) begin
            @(posedge clock);
            #1;
            n++;
        end
        if (round_left == r[7:0]) abort_on_timeout("a round step");
        r = round_left;
        n = 0;
        while (round_left == r[7:0] && n < 100) begin
            @(posedge clock);
            #1;
            n++;
        end
        check_value("cycles per second", 4, n);
        end_test();

        begin_test("order_arrival");
        // the first gap is already partly over
        wait_new_order(steps);
        wait_new_order(steps);
        check_value("seconds between orders", interval_cfg, steps);
        wait_new_order(steps);
        check_value("seconds between orders", interval_cfg, steps);
        check_value("full mask", 15, int'(order_state.active));
        idle_cycles(40);
        end_test();

        begin_test("serve_bonus");
        repeat (4) begin
            n = 0;
            while (!order_state.active[0] && n < 2000) begin
                @(posedge clock);
                #1;
                n++;
            end
            if (!order_state.active[0]) abort_on_timeout("an active order");
            place(1'b1, 4'd4);
            n = 0;
            while (spaces[1] != 4'd0 && n < 100) begin
                @(posedge clock);
                #1;
                n++;
            end
            if (spaces[1] != 4'd0) abort_on_timeout("the serving space to clear");
            idle_cycles(int'($urandom % 20) + 1);
        end
        end_test();

        begin_test("no_serve_other_items");
        item = 4'($urandom % 16);
        if (item == 4'd4) item = 4'd5;
        place(1'b1, item);
        idle_cycles(3);
        check_value("space 1 item", int'(item), int'(spaces[1]));
        item = 4'($urandom % 16);
        if (item == 4'd4) item = 4'd3;
        place(1'b0, item);
        idle_cycles(3);
        check_value("space 0 item", int'(item), int'(spaces[0]));
        place(1'b0, 4'd4);
        idle_cycles(int'($urandom % 8) + 3);
        check_value("dish in space 0", 4, int'(spaces[0]));
        end_test();

        begin_test("expiry");
        n = 0;
        while (!expire_now && n < 2000) begin
            @(posedge clock);
            #1;
            n++;
        end
        if (!expire_now) abort_on_timeout("an order to run out");
        idle_cycles(3);
        end_test();

        begin_test("round_end");
        n = 0;
        while (timer_go && n < 4000) begin
            @(posedge clock);
            #1;
            n++;
        end
        if (timer_go) abort_on_timeout("the round to end");
        idle_cycles(20);
        check_value("round_left at end", 0, int'(round_left));
        end_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // whole-run limit
    initial begin
        #500000;
        $display("simulation ran past its time limit");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- kitchen_top.f
kitchen_pkg.sv
kitchen_config_regs.sv
game_timer.sv
serving_station.sv
order_tracker.sv
kitchen_top.sv
kitchen_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run with Verilator, pass only if the pass line is printed
verilator --binary --timing --assert -f kitchen_top.f \
    --top-module kitchen_top_tb -o kitchen_sim \
    && ./obj_dir/kitchen_sim | tee /dev/stderr | grep -q "TESTS PASSED" \
    && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }
